/* include/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

//////////////////////////////////////////////////
// Execute stage widths
//////////////////////////////////////////////////

// Datapath width of the GPR operands and results
`define DATA_W 32

// GPR address, 32 registers
`define REG_ADDR_W 5

// Shift amount, covers 0..31
`define SHAMT_W 5

`endif

/* source/ex_pkg.sv */
`include "ex_defs.svh"

package ex_pkg;

    //////////////////////////////////////////////////
    // Operation encodings
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_addu = 4'd1,
        alu_sub  = 4'd2,
        alu_subu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_lui  = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        sh_sll = 2'd0,
        sh_srl = 2'd1,
        sh_sra = 2'd2
    } shift_op_t;

    // Source of the EX result
    typedef enum logic [1:0] {
        res_alu    = 2'd0,
        res_shift  = 2'd1,
        res_pass_a = 2'd2
    } exres_sel_t;

    typedef enum logic [1:0] {
        mv_none = 2'd0,
        mv_movz = 2'd1,
        mv_movn = 2'd2
    } move_t;

    //////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`DATA_W-1:0]     op_a;
        logic [`DATA_W-1:0]     op_b;
        logic [`DATA_W-1:0]     imm;
        logic [`REG_ADDR_W-1:0] rs_addr;
        logic [`REG_ADDR_W-1:0] rt_addr;
        logic [`REG_ADDR_W-1:0] rd_addr;
        alu_op_t                alu_op;
        shift_op_t              shift_op;
        logic [`SHAMT_W-1:0]    shamt;
        logic                   shamt_sel;  // 1 takes rs[4:0]
        logic                   b_sel;      // 1 takes the immediate
        exres_sel_t             exres_sel;
        move_t                  move;
        logic                   of_trap;
        logic                   reg_w;
    } idex_t;

    typedef struct packed {
        logic [`DATA_W-1:0]     result;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic                   reg_w;
    } exmem_t;

endpackage

/* source/stage_reg.sv */
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Stall wins over flush, flush inserts a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (!stall) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

/* source/forward_unit.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module forward_unit
    import ex_pkg::*;
(
    // Sources of the instruction in EX
    input  logic [`REG_ADDR_W-1:0] ex_rs_addr,
    input  logic [`REG_ADDR_W-1:0] ex_rt_addr,
    input  logic [`DATA_W-1:0]     ex_op_a,
    input  logic [`DATA_W-1:0]     ex_op_b,
    // EX/MEM register
    input  logic [`REG_ADDR_W-1:0] mem_rd_addr,
    input  logic                   mem_reg_w,
    input  logic [`DATA_W-1:0]     mem_result,
    // Write-back port
    input  logic [`REG_ADDR_W-1:0] wb_rd_addr,
    input  logic                   wb_reg_w,
    input  logic [`DATA_W-1:0]     wb_data,
    output logic [`DATA_W-1:0]     fwd_a,
    output logic [`DATA_W-1:0]     fwd_b
);

    // Newest producer first, $0 always reads the ID/EX value
    function automatic logic [`DATA_W-1:0] pick_operand(
        input logic [`REG_ADDR_W-1:0] src_addr,
        input logic [`DATA_W-1:0]     id_value
    );
        logic [`DATA_W-1:0] value;
        logic               nonzero;
        nonzero = (src_addr != '0);
        if (nonzero && mem_reg_w && (mem_rd_addr == src_addr)) begin
            value = mem_result;
        end else if (nonzero && wb_reg_w && (wb_rd_addr == src_addr)) begin
            value = wb_data;
        end else begin
            value = id_value;
        end
        return value;
    endfunction

    always_comb begin
        fwd_a = pick_operand(ex_rs_addr, ex_op_a);
        fwd_b = pick_operand(ex_rt_addr, ex_op_b);
    end

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module alu
    import ex_pkg::*;
(
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  logic               b_sel,
    input  logic [`DATA_W-1:0] imm,
    input  alu_op_t            op,
    output logic [`DATA_W-1:0] result,
    output logic               overflow
);

    localparam int msb = `DATA_W - 1;

    logic [`DATA_W-1:0] b_mux;
    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic               add_of;
    logic               sub_of;
    logic               lt_signed;
    logic               lt_unsigned;

    // Operand B input mux, immediate for I-type and lui
    assign b_mux = b_sel ? imm : b;

    assign sum  = a + b_mux;
    assign diff = a - b_mux;

    // Same signs in, other sign out
    assign add_of = (a[msb] == b_mux[msb]) && (sum[msb] != a[msb]);
    assign sub_of = (a[msb] != b_mux[msb]) && (diff[msb] != a[msb]);

    assign lt_signed   = $signed(a) < $signed(b_mux);
    assign lt_unsigned = a < b_mux;

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            alu_add: begin
                result   = sum;
                overflow = add_of;
            end
            alu_addu: result = sum;
            alu_sub: begin
                result   = diff;
                overflow = sub_of;
            end
            alu_subu: result = diff;
            alu_and:  result = a & b_mux;
            alu_or:   result = a | b_mux;
            alu_xor:  result = a ^ b_mux;
            alu_nor:  result = ~(a | b_mux);
            alu_slt:  result = {{(`DATA_W-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`DATA_W-1){1'b0}}, lt_unsigned};
            // Upper half from the immediate
            alu_lui:  result = {b_mux[`DATA_W-17:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

/* source/barrel_shifter.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module barrel_shifter
    import ex_pkg::*;
(
    input  logic [`DATA_W-1:0]  value,
    input  logic                shamt_sel,
    input  logic [`SHAMT_W-1:0] shamt,
    input  logic [`DATA_W-1:0]  fwd_a,
    input  shift_op_t           op,
    output logic [`DATA_W-1:0]  result
);

    logic [`SHAMT_W-1:0] amount;
    logic                fill;
    logic [`DATA_W-1:0]  level [`SHAMT_W+1];

    // Variable shifts take rs[4:0]
    assign amount = shamt_sel ? fwd_a[`SHAMT_W-1:0] : shamt;

    // Vacated bits on right shifts, sign only for sra
    assign fill = (op == sh_sra) & value[`DATA_W-1];

    assign level[0] = value;

    // One stage per amount bit, stage i moves by 2**i
    for (genvar i = 0; i < `SHAMT_W; i++) begin : g_step
        localparam int step = 1 << i;

        assign level[i+1] = !amount[i] ? level[i] :
                            (op == sh_sll) ? {level[i][`DATA_W-step-1:0], {step{1'b0}}} :
                            {{step{fill}}, level[i][`DATA_W-1:step]};
    end

    assign result = level[`SHAMT_W];

endmodule

/* source/ex_result_select.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module ex_result_select
    import ex_pkg::*;
(
    input  exres_sel_t         exres_sel,
    input  logic [`DATA_W-1:0] alu_result,
    input  logic [`DATA_W-1:0] shift_result,
    input  logic [`DATA_W-1:0] fwd_a,
    input  logic [`DATA_W-1:0] fwd_b,
    input  move_t              move,
    input  logic               of_trap,
    input  logic               overflow,
    input  logic               reg_w_in,
    output logic [`DATA_W-1:0] result,
    output logic               reg_w
);

    logic rt_zero;
    logic move_block;
    logic trap_block;

    always_comb begin
        case (exres_sel)
            res_alu:    result = alu_result;
            res_shift:  result = shift_result;
            // movz, movn and friends just carry rs
            res_pass_a: result = fwd_a;
            default:    result = alu_result;
        endcase
    end

    // Conditional move tests the forwarded rt
    assign rt_zero    = (fwd_b == '0);
    assign move_block = ((move == mv_movz) && !rt_zero) ||
                        ((move == mv_movn) && rt_zero);

    // add/sub that trap leave the destination untouched
    assign trap_block = of_trap & overflow;

    assign reg_w = reg_w_in & ~move_block & ~trap_block;

endmodule

/* source/ex_stage.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    // Decoded instruction from ID
    input  logic [`DATA_W-1:0]     id_op_a,
    input  logic [`DATA_W-1:0]     id_op_b,
    input  logic [`DATA_W-1:0]     id_imm,
    input  logic [`REG_ADDR_W-1:0] id_rs_addr,
    input  logic [`REG_ADDR_W-1:0] id_rt_addr,
    input  logic [`REG_ADDR_W-1:0] id_rd_addr,
    input  alu_op_t                id_alu_op,
    input  shift_op_t              id_shift_op,
    input  logic [`SHAMT_W-1:0]    id_shamt,
    input  logic                   id_shamt_sel,
    input  logic                   id_b_sel,
    input  exres_sel_t             id_exres_sel,
    input  move_t                  id_move,
    input  logic                   id_of_trap,
    input  logic                   id_reg_w,
    // Write-back port
    input  logic [`DATA_W-1:0]     wb_data,
    input  logic [`REG_ADDR_W-1:0] wb_rd_addr,
    input  logic                   wb_reg_w,
    // EX/MEM outputs
    output logic [`DATA_W-1:0]     mem_result,
    output logic [`REG_ADDR_W-1:0] mem_rd_addr,
    output logic                   mem_reg_w
);

    idex_t              id_payload;
    idex_t              ex_q;
    exmem_t             ex_payload;
    exmem_t             mem_q;
    logic [`DATA_W-1:0] fwd_a;
    logic [`DATA_W-1:0] fwd_b;
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] shift_result;
    logic [`DATA_W-1:0] ex_result;
    logic               ex_overflow;
    logic               ex_reg_w;

    //////////////////////////////////////////////////
    // ID/EX register
    //////////////////////////////////////////////////

    assign id_payload = '{
        op_a:      id_op_a,
        op_b:      id_op_b,
        imm:       id_imm,
        rs_addr:   id_rs_addr,
        rt_addr:   id_rt_addr,
        rd_addr:   id_rd_addr,
        alu_op:    id_alu_op,
        shift_op:  id_shift_op,
        shamt:     id_shamt,
        shamt_sel: id_shamt_sel,
        b_sel:     id_b_sel,
        exres_sel: id_exres_sel,
        move:      id_move,
        of_trap:   id_of_trap,
        reg_w:     id_reg_w
    };

    stage_reg #(.payload_t(idex_t)) u_idex_reg (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .stall ( stall      ),
        .flush ( flush      ),
        .d     ( id_payload ),
        .q     ( ex_q       )
    );

    //////////////////////////////////////////////////
    // EX
    //////////////////////////////////////////////////

    forward_unit u_forward_unit (
        .ex_rs_addr  ( ex_q.rs_addr  ),
        .ex_rt_addr  ( ex_q.rt_addr  ),
        .ex_op_a     ( ex_q.op_a     ),
        .ex_op_b     ( ex_q.op_b     ),
        .mem_rd_addr ( mem_q.rd_addr ),
        .mem_reg_w   ( mem_q.reg_w   ),
        .mem_result  ( mem_q.result  ),
        .wb_rd_addr  ( wb_rd_addr    ),
        .wb_reg_w    ( wb_reg_w      ),
        .wb_data     ( wb_data       ),
        .fwd_a       ( fwd_a         ),
        .fwd_b       ( fwd_b         )
    );

    alu u_alu (
        .a        ( fwd_a       ),
        .b        ( fwd_b       ),
        .b_sel    ( ex_q.b_sel  ),
        .imm      ( ex_q.imm    ),
        .op       ( ex_q.alu_op ),
        .result   ( alu_result  ),
        .overflow ( ex_overflow )
    );

    // Shifts operate on rt
    barrel_shifter u_barrel_shifter (
        .value     ( fwd_b          ),
        .shamt_sel ( ex_q.shamt_sel ),
        .shamt     ( ex_q.shamt     ),
        .fwd_a     ( fwd_a          ),
        .op        ( ex_q.shift_op  ),
        .result    ( shift_result   )
    );

    ex_result_select u_ex_result_select (
        .exres_sel    ( ex_q.exres_sel ),
        .alu_result   ( alu_result     ),
        .shift_result ( shift_result   ),
        .fwd_a        ( fwd_a          ),
        .fwd_b        ( fwd_b          ),
        .move         ( ex_q.move      ),
        .of_trap      ( ex_q.of_trap   ),
        .overflow     ( ex_overflow    ),
        .reg_w_in     ( ex_q.reg_w     ),
        .result       ( ex_result      ),
        .reg_w        ( ex_reg_w       )
    );

    //////////////////////////////////////////////////
    // EX/MEM register
    //////////////////////////////////////////////////

    assign ex_payload = '{result: ex_result, rd_addr: ex_q.rd_addr, reg_w: ex_reg_w};

    stage_reg #(.payload_t(exmem_t)) u_exmem_reg (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .stall ( stall      ),
        .flush ( flush      ),
        .d     ( ex_payload ),
        .q     ( mem_q      )
    );

    assign mem_result  = mem_q.result;
    assign mem_rd_addr = mem_q.rd_addr;
    assign mem_reg_w   = mem_q.reg_w;

endmodule

/* verification/ex_stage_chk.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module ex_stage_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   stall,
    input logic                   flush,
    input logic [`DATA_W-1:0]     mem_result,
    input logic [`REG_ADDR_W-1:0] mem_rd_addr,
    input logic                   mem_reg_w
);

    //////////////////////////////////////////////////
    // Stage register control
    //////////////////////////////////////////////////

    // A stalled edge leaves EX/MEM untouched
    stall_holds_outputs: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> ($stable(mem_result) && $stable(mem_rd_addr) && $stable(mem_reg_w))
    ) else $error("mem outputs changed during stall");

    // The bubble reaches EX/MEM one edge after the flush
    flush_gives_bubble: assert property (
        @(posedge clk) disable iff (rst)
        (flush && !stall) ##1 !stall |=> !mem_reg_w
    ) else $error("mem_reg_w high after flush");

    reset_clears_write: assert property (
        @(posedge clk)
        rst |=> !mem_reg_w
    ) else $error("mem_reg_w high after reset");

endmodule

/* verification/ex_stage_tb.sv */
`timescale 1ns/100ps

`include "ex_defs.svh"

module ex_stage_tb
    import ex_pkg::*;
;

    typedef struct {
        bit rnd;
        logic [`DATA_W-1:0] op_a;
        logic [`DATA_W-1:0] op_b;
        logic [`DATA_W-1:0] imm;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        alu_op_t alu_op;
        shift_op_t shift_op;
        logic [`SHAMT_W-1:0] shamt;
        logic shamt_sel;
        logic b_sel;
        exres_sel_t exres_sel;
        move_t move;
        logic of_trap;
        logic reg_w;
        logic [`DATA_W-1:0] wb_data;
        logic [`REG_ADDR_W-1:0] wb_rd;
        logic wb_w;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   stall;
    logic                   flush;
    logic [`DATA_W-1:0]     id_op_a;
    logic [`DATA_W-1:0]     id_op_b;
    logic [`DATA_W-1:0]     id_imm;
    logic [`REG_ADDR_W-1:0] id_rs_addr;
    logic [`REG_ADDR_W-1:0] id_rt_addr;
    logic [`REG_ADDR_W-1:0] id_rd_addr;
    alu_op_t                id_alu_op;
    shift_op_t              id_shift_op;
    logic [`SHAMT_W-1:0]    id_shamt;
    logic                   id_shamt_sel;
    logic                   id_b_sel;
    exres_sel_t             id_exres_sel;
    move_t                  id_move;
    logic                   id_of_trap;
    logic                   id_reg_w;
    logic [`DATA_W-1:0]     wb_data;
    logic [`REG_ADDR_W-1:0] wb_rd_addr;
    logic                   wb_reg_w;
    logic [`DATA_W-1:0]     mem_result;
    logic [`REG_ADDR_W-1:0] mem_rd_addr;
    logic                   mem_reg_w;

    row_t               rows[$];
    logic [`DATA_W-1:0] exp_res[$];
    logic               exp_w[$];
    int                 errors = 0;
    int                 cycles = 0;
    int                 timeout_cycles = 100000;

    ex_stage u_ex_stage (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [`DATA_W-1:0] forward_ref(
        input logic [`REG_ADDR_W-1:0] addr, input logic [`DATA_W-1:0] id_val,
        input logic [`DATA_W-1:0] m_res, input logic [`REG_ADDR_W-1:0] m_rd,
        input logic m_w, input row_t r
    );
        if (addr == 0) return id_val;
        if (m_w && m_rd == addr) return m_res;
        if (r.wb_w && r.wb_rd == addr) return r.wb_data;
        return id_val;
    endfunction

    // Returns {reg_w, result}
    function automatic logic [`DATA_W:0] execute_ref(
        input row_t r, input logic [`DATA_W-1:0] m_res,
        input logic [`REG_ADDR_W-1:0] m_rd, input logic m_w
    );
        logic [`DATA_W-1:0] fa;
        logic [`DATA_W-1:0] fb;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] alu_r;
        logic [`DATA_W-1:0] sh_r;
        logic [`DATA_W-1:0] res;
        logic [`DATA_W:0]   wide;
        logic               ovf;
        logic               w;
        int                 amt;
        fa = forward_ref(r.rs, r.op_a, m_res, m_rd, m_w, r);
        fb = forward_ref(r.rt, r.op_b, m_res, m_rd, m_w, r);
        b = r.b_sel ? r.imm : fb;
        ovf = 1'b0;
        case (r.alu_op)
            alu_add, alu_addu: begin
                wide = $signed({fa[31], fa}) + $signed({b[31], b});
                alu_r = wide[31:0];
                ovf = (r.alu_op == alu_add) && (wide[32] != wide[31]);
            end
            alu_sub, alu_subu: begin
                wide = $signed({fa[31], fa}) - $signed({b[31], b});
                alu_r = wide[31:0];
                ovf = (r.alu_op == alu_sub) && (wide[32] != wide[31]);
            end
            alu_and:  alu_r = fa & b;
            alu_or:   alu_r = fa | b;
            alu_xor:  alu_r = fa ^ b;
            alu_nor:  alu_r = ~(fa | b);
            alu_slt:  alu_r = ($signed(fa) < $signed(b)) ? 1 : 0;
            alu_sltu: alu_r = (fa < b) ? 1 : 0;
            default:  alu_r = b << 16;
        endcase
        amt = r.shamt_sel ? fa[4:0] : r.shamt;
        case (r.shift_op)
            sh_sll:  sh_r = fb << amt;
            sh_srl:  sh_r = fb >> amt;
            default: sh_r = $signed(fb) >>> amt;
        endcase
        res = (r.exres_sel == res_shift) ? sh_r : (r.exres_sel == res_pass_a) ? fa : alu_r;
        w = r.reg_w && !(r.of_trap && ovf);
        if (r.move == mv_movz && fb != 0) w = 1'b0;
        if (r.move == mv_movn && fb == 0) w = 1'b0;
        return {w, res};
    endfunction

    //////////////////////////////////////////////////
    // Table and drivers
    //////////////////////////////////////////////////

    task automatic add_row(
        input bit rnd, input logic [31:0] a, b, imm,
        input logic [`REG_ADDR_W-1:0] rs, rt, rd,
        input alu_op_t aop, input shift_op_t sop, input logic [`SHAMT_W-1:0] shamt,
        input bit shsel, input bit bsel, input exres_sel_t sel, input move_t mv,
        input bit trap, input logic [31:0] wbd, input logic [`REG_ADDR_W-1:0] wbrd,
        input bit wbw
    );
        row_t r;
        r = '{rnd, a, b, imm, rs, rt, rd, aop, sop, shamt, shsel, bsel, sel, mv,
              trap, 1'b1, wbd, wbrd, wbw};
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r, input logic [`DATA_W-1:0] wbd,
                             input logic [`REG_ADDR_W-1:0] wbrd, input logic wbw);
        id_op_a = r.op_a;
        id_op_b = r.op_b;
        id_imm = r.imm;
        id_rs_addr = r.rs;
        id_rt_addr = r.rt;
        id_rd_addr = r.rd;
        id_alu_op = r.alu_op;
        id_shift_op = r.shift_op;
        id_shamt = r.shamt;
        id_shamt_sel = r.shamt_sel;
        id_b_sel = r.b_sel;
        id_exres_sel = r.exres_sel;
        id_move = r.move;
        id_of_trap = r.of_trap;
        id_reg_w = r.reg_w;
        // WB port belongs to the row now in EX
        wb_data = wbd;
        wb_rd_addr = wbrd;
        wb_reg_w = wbw;
    endtask

    task automatic check_outputs(input string what, input logic [`DATA_W-1:0] er,
                                 input logic [`REG_ADDR_W-1:0] erd, input logic ew);
        if (mem_result !== er) begin
            errors++;
            $display("[FAIL] %s mem_result got %h expected %h", what, mem_result, er);
        end
        if (mem_rd_addr !== erd) begin
            errors++;
            $display("[FAIL] %s mem_rd_addr got %h expected %h", what, mem_rd_addr, erd);
        end
        if (mem_reg_w !== ew) begin
            errors++;
            $display("[FAIL] %s mem_reg_w got %h expected %h", what, mem_reg_w, ew);
        end
    endtask

    initial begin
        row_t               idle;
        row_t               ra;
        row_t               rb;
        logic [`DATA_W:0]   ea;
        logic [`DATA_W:0]   eb;
        logic [`DATA_W:0]   e;
        logic [`DATA_W-1:0] m_res;
        logic [`REG_ADDR_W-1:0] m_rd;
        logic               m_w;
        int                 n;
        idle = '{default: '0, alu_op: alu_add, shift_op: sh_sll,
                 exres_sel: res_alu, move: mv_none};
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        drive_row(idle, 0, 0, 0);
        void'($urandom(17));

        // ALU with register and immediate operand B
        add_row(1, 0, 0, 0, 1, 2, 3, alu_add, sh_sll, 0, 0, 0, res_alu, mv_none, 0, 0, 0, 0);
        add_row(1, 0, 0, 32'h0000_7fff, 4, 5, 6, alu_addu, sh_sll, 0, 0, 1, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(1, 0, 0, 0, 7, 8, 9, alu_sub, sh_sll, 0, 0, 0, res_alu, mv_none, 0, 0, 0, 0);
        add_row(1, 0, 0, 0, 1, 2, 10, alu_subu, sh_sll, 0, 0, 0, res_alu, mv_none, 0, 0, 0, 0);
        add_row(0, 32'hf0f0_1234, 0, 32'h0000_ff0f, 13, 2, 11, alu_and, sh_sll, 0, 0, 1,
                res_alu, mv_none, 0, 0, 0, 0);
        add_row(1, 0, 0, 0, 1, 2, 12, alu_or, sh_sll, 0, 0, 0, res_alu, mv_none, 0, 0, 0, 0);
        add_row(0, 32'h1234_5678, 0, 32'hffff_8001, 13, 2, 14, alu_xor, sh_sll, 0, 0, 1,
                res_alu, mv_none, 0, 0, 0, 0);
        add_row(1, 0, 0, 0, 1, 2, 15, alu_nor, sh_sll, 0, 0, 0, res_alu, mv_none, 0, 0, 0, 0);
        add_row(0, 32'hffff_fff0, 5, 0, 1, 2, 17, alu_slt, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'hffff_fff0, 5, 0, 1, 2, 19, alu_sltu, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 0, 0, 32'h0000_1234, 0, 0, 20, alu_lui, sh_sll, 0, 0, 1, res_alu, mv_none,
                0, 0, 0, 0);
        // Shifts with the amount from shamt and from rs
        add_row(0, 0, 32'h8000_00f1, 0, 1, 2, 21, alu_add, sh_sll, 4, 0, 0, res_shift, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'h27, 32'hf000_0000, 0, 1, 2, 22, alu_add, sh_srl, 0, 1, 0, res_shift,
                mv_none, 0, 0, 0, 0);
        add_row(0, 0, 32'h8765_4321, 0, 1, 2, 23, alu_add, sh_sra, 8, 0, 0, res_shift, mv_none,
                0, 0, 0, 0);
        // Forwarding from MEM, then WB, then both, then $0
        add_row(0, 32'h100, 32'h23, 0, 14, 15, 16, alu_addu, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'hdead, 1, 0, 16, 17, 18, alu_or, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'hffff, 7, 0, 19, 18, 24, alu_and, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'h1111, 32'h2222, 0, 20, 21, 25, alu_xor, sh_sll, 0, 0, 0, res_alu,
                mv_none, 0, 32'h5555_aaaa, 20, 1);
        add_row(0, 32'h300, 32'h45, 0, 1, 2, 26, alu_addu, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'h9, 32'h1, 0, 26, 2, 27, alu_addu, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 32'h0bad_0bad, 26, 1);
        add_row(0, 32'h50, 32'h5, 0, 1, 2, 0, alu_addu, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 0, 0, 0);
        add_row(0, 32'h77, 32'h1, 0, 0, 2, 28, alu_addu, sh_sll, 0, 0, 0, res_alu, mv_none,
                0, 32'hcafe_f00d, 0, 1);
        // Conditional moves and trapping overflow
        add_row(0, 32'habc, 0, 0, 29, 30, 5, alu_add, sh_sll, 0, 0, 0, res_pass_a, mv_movz,
                0, 0, 0, 0);
        add_row(0, 32'habc, 5, 0, 29, 30, 6, alu_add, sh_sll, 0, 0, 0, res_pass_a, mv_movz,
                0, 0, 0, 0);
        add_row(0, 32'hdef, 5, 0, 29, 30, 7, alu_add, sh_sll, 0, 0, 0, res_pass_a, mv_movn,
                0, 0, 0, 0);
        add_row(0, 32'hdef, 0, 0, 29, 30, 8, alu_add, sh_sll, 0, 0, 0, res_pass_a, mv_movn,
                0, 0, 0, 0);
        add_row(0, 32'h7fff_ffff, 1, 0, 1, 2, 9, alu_add, sh_sll, 0, 0, 0, res_alu, mv_none,
                1, 0, 0, 0);
        add_row(0, 32'h8000_0000, 1, 0, 1, 2, 10, alu_sub, sh_sll, 0, 0, 0, res_alu, mv_none,
                1, 0, 0, 0);
        add_row(0, 32'h1, 32'h2, 0, 1, 2, 11, alu_add, sh_sll, 0, 0, 0, res_alu, mv_none,
                1, 0, 0, 0);

        // Expected values with EX/MEM empty after reset
        n = rows.size();
        timeout_cycles = n * 4 + 50;
        m_res = '0;
        m_rd = '0;
        m_w = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (rows[i].rnd) begin
                rows[i].op_a = $urandom;
                rows[i].op_b = $urandom;
            end
            e = execute_ref(rows[i], m_res, m_rd, m_w);
            exp_res.push_back(e[`DATA_W-1:0]);
            exp_w.push_back(e[`DATA_W]);
            m_res = e[`DATA_W-1:0];
            m_rd = rows[i].rd;
            m_w = e[`DATA_W];
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (mem_reg_w !== 1'b0) begin
            errors++;
            $display("[FAIL] reset mem_reg_w got %h expected %h", mem_reg_w, 1'b0);
        end

        //////////////////////////////////////////////////
        // Table loop with one row per cycle
        //////////////////////////////////////////////////
        for (int c = 0; c < n + 2; c++) begin
            @(negedge clk);
            if (c >= 2) begin
                check_outputs($sformatf("row %0d", c - 2), exp_res[c - 2], rows[c - 2].rd,
                              exp_w[c - 2]);
            end
            if (c >= 1 && c <= n) begin
                drive_row(c < n ? rows[c] : idle, rows[c - 1].wb_data, rows[c - 1].wb_rd,
                          rows[c - 1].wb_w);
            end else begin
                drive_row(c < n ? rows[c] : idle, 0, 0, 0);
            end
        end

        // Stall for three edges with A in EX/MEM and B in ID/EX
        ra = idle;
        ra.op_a = 32'h4000;
        ra.imm = 32'h0000_0321;
        ra.b_sel = 1'b1;
        ra.alu_op = alu_addu;
        ra.rd = 11;
        ra.reg_w = 1'b1;
        rb = ra;
        rb.alu_op = alu_subu;
        rb.rd = 12;
        ea = execute_ref(ra, 0, 0, 0);
        eb = execute_ref(rb, ea[`DATA_W-1:0], ra.rd, ea[`DATA_W]);
        drive_row(ra, 0, 0, 0);
        @(negedge clk);
        drive_row(rb, 0, 0, 0);
        @(negedge clk);
        stall = 1'b1;
        drive_row(idle, 0, 0, 0);
        check_outputs("stall start", ea[`DATA_W-1:0], ra.rd, ea[`DATA_W]);
        repeat (3) begin
            @(negedge clk);
            check_outputs("stall hold", ea[`DATA_W-1:0], ra.rd, ea[`DATA_W]);
        end
        stall = 1'b0;
        @(negedge clk);
        check_outputs("after stall", eb[`DATA_W-1:0], rb.rd, eb[`DATA_W]);

        // Flush row never writes
        flush = 1'b1;
        drive_row(ra, 0, 0, 0);
        @(negedge clk);
        flush = 1'b0;
        drive_row(idle, 0, 0, 0);
        @(negedge clk);
        if (mem_reg_w !== 1'b0) begin
            errors++;
            $display("[FAIL] flush mem_reg_w got %h expected %h", mem_reg_w, 1'b0);
        end

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

bind ex_stage ex_stage_chk u_ex_stage_chk (
    .clk         ( clk         ),
    .rst         ( rst         ),
    .stall       ( stall       ),
    .flush       ( flush       ),
    .mem_result  ( mem_result  ),
    .mem_rd_addr ( mem_rd_addr ),
    .mem_reg_w   ( mem_reg_w   )
);

/* all.f */
+incdir+include
source/ex_pkg.sv
source/stage_reg.sv
source/forward_unit.sv
source/alu.sv
source/barrel_shifter.sv
source/ex_result_select.sv
source/ex_stage.sv
verification/ex_stage_chk.sv
verification/ex_stage_tb.sv
